// ==== exec_ctrl_if.sv ====
// Decoded control bundle between the execute control and the datapath
// Also returns the output buffer destination for hazard checks
`timescale 1ns/1ps
`default_nettype none

interface exec_ctrl_if;

    rv32_exec_pkg::imm_type_t  imm_type;
    rv32_exec_pkg::alu_op_t    alu_op;
    rv32_exec_pkg::alu_in_t    alu_in [2];
    rv32_exec_pkg::branch_op_t branch_op;
    rv32_exec_pkg::mul_op_t    mul_op;
    rv32_exec_pkg::wb_src_t    wb_src;
    logic                      reg_write;
    rv32_exec_pkg::bypass_t    bypass_sel [2];
    logic                      slot_valid;

    // Fed back from the exec-to-memory buffer
    rv32_types_pkg::reg_idx_t  buf_rd;
    logic                      buf_reg_write;

    modport ctrl (
        output imm_type, alu_op, alu_in, branch_op, mul_op, wb_src,
        output reg_write, bypass_sel, slot_valid,
        input  buf_rd, buf_reg_write
    );

    modport datapath (
        input  imm_type, alu_op, alu_in, branch_op, mul_op, wb_src,
        input  reg_write, bypass_sel, slot_valid,
        output buf_rd, buf_reg_write
    );

endinterface

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_exec_stage -f src.f -o sim_exec_stage

./obj_dir/sim_exec_stage | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"

// ==== rv32_branch_unit.sv ====
// Branch comparator for conditional branches and unconditional jumps
`timescale 1ns/1ps
`default_nettype none

module rv32_branch_unit (
    input  rv32_types_pkg::rv32_word  op1,
    input  rv32_types_pkg::rv32_word  op2,
    input  rv32_exec_pkg::branch_op_t branch_op,
    output logic                      taken
);

    logic equal, less, less_u;

    assign equal  = op1 == op2;
    assign less   = $signed(op1) < $signed(op2);
    assign less_u = op1 < op2;

    always_comb begin
        case (branch_op)
            rv32_exec_pkg::BEQ:       taken = equal;
            rv32_exec_pkg::BNE:       taken = !equal;
            rv32_exec_pkg::BLT:       taken = less;
            rv32_exec_pkg::BGE:       taken = !less;
            rv32_exec_pkg::BLTU:      taken = less_u;
            rv32_exec_pkg::BGEU:      taken = !less_u;
            rv32_exec_pkg::BR_ALWAYS: taken = 1'b1;
            default:                  taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rv32_exec_ctrl.sv ====
// Execute control with instruction decode and operand bypass selection
`timescale 1ns/1ps
`default_nettype none

module rv32_exec_ctrl (
    input  rv32_types_pkg::rv32_instr_t instr,
    input  logic                        valid,
    input  rv32_types_pkg::reg_idx_t    wb_rd,
    input  logic                        wb_reg_write,
    exec_ctrl_if.ctrl                   ctrl
);

    logic                     known;
    logic                     sub_sra;
    rv32_types_pkg::reg_idx_t src [2];

    assign src[0] = instr.rs1;
    assign src[1] = instr.rs2;

    // Opcode decode
    always_comb begin
        known             = 1'b0;
        sub_sra           = 1'b0;
        ctrl.imm_type     = rv32_exec_pkg::IMM_I;
        ctrl.alu_op       = rv32_exec_pkg::ADD;
        ctrl.alu_in[0]    = rv32_exec_pkg::ALU_IN_ZERO;
        ctrl.alu_in[1]    = rv32_exec_pkg::ALU_IN_ZERO;
        ctrl.branch_op    = rv32_exec_pkg::BR_NONE;
        ctrl.mul_op       = rv32_exec_pkg::mul_op_t'(instr.funct3[1:0]);
        ctrl.wb_src       = rv32_exec_pkg::WB_NONE;
        ctrl.reg_write    = 1'b0;
        case (instr.opcode)
            rv32_types_pkg::OPC_OP: begin
                known          = 1'b1;
                sub_sra        = instr.funct7[5]
                                 && (instr.funct3 == 3'b000 || instr.funct3 == 3'b101);
                ctrl.alu_op    = rv32_exec_pkg::alu_op_t'({sub_sra, instr.funct3});
                ctrl.alu_in[0] = rv32_exec_pkg::ALU_IN_REG_1;
                ctrl.alu_in[1] = rv32_exec_pkg::ALU_IN_REG_2;
                ctrl.wb_src    = instr.funct7[0] ? rv32_exec_pkg::WB_MUL_UNIT
                                                 : rv32_exec_pkg::WB_INT_ALU;
                ctrl.reg_write = 1'b1;
            end
            rv32_types_pkg::OPC_OP_IMM: begin
                known          = 1'b1;
                // Outside SRAI the funct7 bits are immediate bits
                sub_sra        = instr.funct7[5] && instr.funct3 == 3'b101;
                ctrl.alu_op    = rv32_exec_pkg::alu_op_t'({sub_sra, instr.funct3});
                ctrl.alu_in[0] = rv32_exec_pkg::ALU_IN_REG_1;
                ctrl.alu_in[1] = rv32_exec_pkg::ALU_IN_IMM;
                ctrl.wb_src    = rv32_exec_pkg::WB_INT_ALU;
                ctrl.reg_write = 1'b1;
            end
            rv32_types_pkg::OPC_LUI, rv32_types_pkg::OPC_AUIPC: begin
                known          = 1'b1;
                ctrl.imm_type  = rv32_exec_pkg::IMM_U;
                ctrl.alu_in[0] = (instr.opcode == rv32_types_pkg::OPC_LUI)
                                 ? rv32_exec_pkg::ALU_IN_ZERO : rv32_exec_pkg::ALU_IN_PC;
                ctrl.alu_in[1] = rv32_exec_pkg::ALU_IN_IMM;
                ctrl.wb_src    = rv32_exec_pkg::WB_INT_ALU;
                ctrl.reg_write = 1'b1;
            end
            rv32_types_pkg::OPC_JAL, rv32_types_pkg::OPC_JALR: begin
                known          = 1'b1;
                // ALU computes the target and pc + 4 is the link value
                ctrl.imm_type  = (instr.opcode == rv32_types_pkg::OPC_JAL)
                                 ? rv32_exec_pkg::IMM_J : rv32_exec_pkg::IMM_I;
                ctrl.alu_in[0] = (instr.opcode == rv32_types_pkg::OPC_JAL)
                                 ? rv32_exec_pkg::ALU_IN_PC : rv32_exec_pkg::ALU_IN_REG_1;
                ctrl.alu_in[1] = rv32_exec_pkg::ALU_IN_IMM;
                ctrl.branch_op = rv32_exec_pkg::BR_ALWAYS;
                ctrl.wb_src    = rv32_exec_pkg::WB_PC4;
                ctrl.reg_write = 1'b1;
            end
            rv32_types_pkg::OPC_BRANCH: begin
                known          = 1'b1;
                ctrl.imm_type  = rv32_exec_pkg::IMM_B;
                ctrl.alu_in[0] = rv32_exec_pkg::ALU_IN_PC;
                ctrl.alu_in[1] = rv32_exec_pkg::ALU_IN_IMM;
                case (instr.funct3)
                    3'b000:  ctrl.branch_op = rv32_exec_pkg::BEQ;
                    3'b001:  ctrl.branch_op = rv32_exec_pkg::BNE;
                    3'b100:  ctrl.branch_op = rv32_exec_pkg::BLT;
                    3'b101:  ctrl.branch_op = rv32_exec_pkg::BGE;
                    3'b110:  ctrl.branch_op = rv32_exec_pkg::BLTU;
                    3'b111:  ctrl.branch_op = rv32_exec_pkg::BGEU;
                    default: ctrl.branch_op = rv32_exec_pkg::BR_NONE;
                endcase
            end
            rv32_types_pkg::OPC_STORE: begin
                known          = 1'b1;
                ctrl.imm_type  = rv32_exec_pkg::IMM_S;
                ctrl.alu_in[0] = rv32_exec_pkg::ALU_IN_REG_1;
                ctrl.alu_in[1] = rv32_exec_pkg::ALU_IN_IMM;
                ctrl.wb_src    = rv32_exec_pkg::WB_INT_ALU;
            end
            default: ;
        endcase
        ctrl.slot_valid = valid && known;
    end

    // Buffer result is newer than write-back and wins
    always_comb begin
        for (int idx = 0; idx < 2; idx++) begin
            if (ctrl.buf_reg_write && ctrl.buf_rd == src[idx])
                ctrl.bypass_sel[idx] = rv32_exec_pkg::BYPASS_EXEC_BUFF;
            else if (wb_reg_write && wb_rd == src[idx] && wb_rd != '0)
                ctrl.bypass_sel[idx] = rv32_exec_pkg::BYPASS_WB;
            else
                ctrl.bypass_sel[idx] = rv32_exec_pkg::BYPASS_NONE;
        end
    end

endmodule

`default_nettype wire

// ==== rv32_exec_pkg.sv ====
// Execute stage control encodings
// ALU, operand source, branch, multiply, result, bypass and immediate enums
`default_nettype none

package rv32_exec_pkg;

    // Encoded as {funct7[5], funct3} so OP decode is a direct cast
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        OR   = 4'b0110,
        AND  = 4'b0111,
        SUB  = 4'b1000,
        SRA  = 4'b1101
    } alu_op_t;

    typedef enum logic [2:0] {
        ALU_IN_REG_1,
        ALU_IN_REG_2,
        ALU_IN_PC,
        ALU_IN_IMM,
        ALU_IN_ZERO
    } alu_in_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        BR_ALWAYS
    } branch_op_t;

    // Same order as funct3[1:0] of the M extension
    typedef enum logic [1:0] {MUL, MULH, MULHSU, MULHU} mul_op_t;

    typedef enum logic [1:0] {WB_NONE, WB_PC4, WB_INT_ALU, WB_MUL_UNIT} wb_src_t;

    typedef enum logic [1:0] {BYPASS_NONE, BYPASS_EXEC_BUFF, BYPASS_WB} bypass_t;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_type_t;

endpackage

`default_nettype wire

// ==== rv32_exec_stage.sv ====
// RV32 execute stage top level
// Operand bypass, ALU crossbar, result select and the exec-to-memory buffer
`timescale 1ns/1ps
`default_nettype none

module rv32_exec_stage (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     valid,
    input  logic                     stop,
    input  rv32_types_pkg::rv32_word instr,
    input  rv32_types_pkg::rv32_word pc,
    input  rv32_types_pkg::rv32_word rs1_data,
    input  rv32_types_pkg::rv32_word rs2_data,
    input  rv32_types_pkg::rv32_word wb_bypass,
    input  rv32_types_pkg::reg_idx_t wb_rd,
    input  logic                     wb_reg_write,
    output logic                     do_jump,
    output rv32_types_pkg::rv32_word jump_addr,
    output logic                     out_valid,
    output logic                     out_reg_write,
    output rv32_types_pkg::reg_idx_t out_rd,
    output rv32_types_pkg::rv32_word result,
    output rv32_types_pkg::rv32_word store_data,
    output rv32_types_pkg::rv32_word out_pc,
    output rv32_types_pkg::rv32_word out_instr
);

    rv32_types_pkg::rv32_instr_t instr_f;
    rv32_types_pkg::rv32_word    src_data [2];
    rv32_types_pkg::rv32_word    reg_data [2];
    rv32_types_pkg::rv32_word    alu_opnd [2];
    rv32_types_pkg::rv32_word    immediate, alu_result, mul_result, next_result;
    logic                        taken;

    exec_ctrl_if ctrl_bus ();

    assign instr_f     = instr;
    assign src_data[0] = rs1_data;
    assign src_data[1] = rs2_data;

    rv32_exec_ctrl exec_ctrl (
        .instr(instr_f), .valid(valid),
        .wb_rd(wb_rd), .wb_reg_write(wb_reg_write),
        .ctrl(ctrl_bus.ctrl)
    );

    // Forwarded register operands
    always_comb begin
        for (int idx = 0; idx < 2; idx++) begin
            case (ctrl_bus.bypass_sel[idx])
                rv32_exec_pkg::BYPASS_EXEC_BUFF: reg_data[idx] = result;
                rv32_exec_pkg::BYPASS_WB:        reg_data[idx] = wb_bypass;
                default:                         reg_data[idx] = src_data[idx];
            endcase
        end
    end

    rv32_immediate_gen immediate_gen (
        .imm_type(ctrl_bus.imm_type), .instr(instr_f), .immediate(immediate)
    );

    // ALU operand crossbar
    always_comb begin
        for (int idx = 0; idx < 2; idx++) begin
            case (ctrl_bus.alu_in[idx])
                rv32_exec_pkg::ALU_IN_REG_1: alu_opnd[idx] = reg_data[0];
                rv32_exec_pkg::ALU_IN_REG_2: alu_opnd[idx] = reg_data[1];
                rv32_exec_pkg::ALU_IN_PC:    alu_opnd[idx] = pc;
                rv32_exec_pkg::ALU_IN_IMM:   alu_opnd[idx] = immediate;
                default:                     alu_opnd[idx] = '0;
            endcase
        end
    end

    rv32_int_alu int_alu (
        .op1(alu_opnd[0]), .op2(alu_opnd[1]),
        .opsel(ctrl_bus.alu_op), .result(alu_result)
    );

    rv32_branch_unit branch_unit (
        .op1(reg_data[0]), .op2(reg_data[1]),
        .branch_op(ctrl_bus.branch_op), .taken(taken)
    );

    rv32_mul_unit mul_unit (
        .op1(reg_data[0]), .op2(reg_data[1]),
        .opsel(ctrl_bus.mul_op), .result(mul_result)
    );

    // Jump target comes straight from the ALU, same cycle
    assign do_jump   = taken && ctrl_bus.slot_valid;
    assign jump_addr = {alu_result[31:1], 1'b0};

    always_comb begin
        case (ctrl_bus.wb_src)
            rv32_exec_pkg::WB_PC4:      next_result = pc + 32'd4;
            rv32_exec_pkg::WB_INT_ALU:  next_result = alu_result;
            rv32_exec_pkg::WB_MUL_UNIT: next_result = mul_result;
            default:                    next_result = '0;
        endcase
    end

    // Buffer control fields
    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_valid     <= 1'b0;
            out_reg_write <= 1'b0;
            out_rd        <= '0;
            out_pc        <= '0;
            out_instr     <= rv32_types_pkg::RV_NOP;
        end else if (!stop) begin
            out_valid     <= ctrl_bus.slot_valid;
            // x0 is never marked as written, so it never forwards
            out_reg_write <= ctrl_bus.slot_valid && ctrl_bus.reg_write && instr_f.rd != '0;
            out_rd        <= instr_f.rd;
            out_pc        <= pc;
            out_instr     <= instr;
        end
    end

    // Buffer payload
    always_ff @(posedge clk) begin
        if (!stop) begin
            result     <= next_result;
            store_data <= reg_data[1];
        end
    end

    assign ctrl_bus.buf_rd        = out_rd;
    assign ctrl_bus.buf_reg_write = out_reg_write;

    a_valid_known: assert property (
        @(posedge clk) disable iff (!resetn) !$isunknown(out_valid)
    ) else $error("out_valid unknown");

    a_stop_holds: assert property (
        @(posedge clk) disable iff (!resetn)
        stop |=> $stable({out_valid, out_reg_write, out_rd, result, store_data,
                          out_pc, out_instr})
    ) else $error("buffer changed while stopped");

endmodule

`default_nettype wire

// ==== rv32_immediate_gen.sv ====
// Sign-extended immediate builder for the I, S, B, U and J formats
`timescale 1ns/1ps
`default_nettype none

module rv32_immediate_gen (
    input  rv32_exec_pkg::imm_type_t    imm_type,
    input  rv32_types_pkg::rv32_instr_t instr,
    output rv32_types_pkg::rv32_word    immediate
);

    rv32_types_pkg::rv32_word raw;

    assign raw = instr;

    always_comb begin
        case (imm_type)
            rv32_exec_pkg::IMM_S: immediate = {{20{raw[31]}}, raw[31:25], raw[11:7]};
            rv32_exec_pkg::IMM_B: immediate = {{19{raw[31]}}, raw[31], raw[7],
                                               raw[30:25], raw[11:8], 1'b0};
            rv32_exec_pkg::IMM_U: immediate = {raw[31:12], 12'b0};
            rv32_exec_pkg::IMM_J: immediate = {{11{raw[31]}}, raw[31], raw[19:12],
                                               raw[20], raw[30:21], 1'b0};
            // I format
            default:              immediate = {{20{raw[31]}}, raw[31:20]};
        endcase
    end

endmodule

`default_nettype wire

// ==== rv32_int_alu.sv ====
// Integer ALU: add, sub, shifts, compares and bitwise logic
`timescale 1ns/1ps
`default_nettype none

module rv32_int_alu (
    input  rv32_types_pkg::rv32_word op1,
    input  rv32_types_pkg::rv32_word op2,
    input  rv32_exec_pkg::alu_op_t   opsel,
    output rv32_types_pkg::rv32_word result
);

    logic [4:0] shamt;

    assign shamt = op2[4:0];

    always_comb begin
        case (opsel)
            rv32_exec_pkg::ADD:  result = op1 + op2;
            rv32_exec_pkg::SUB:  result = op1 - op2;
            rv32_exec_pkg::SLL:  result = op1 << shamt;
            rv32_exec_pkg::SLT:  result = {31'b0, $signed(op1) < $signed(op2)};
            rv32_exec_pkg::SLTU: result = {31'b0, op1 < op2};
            rv32_exec_pkg::XOR:  result = op1 ^ op2;
            rv32_exec_pkg::SRL:  result = op1 >> shamt;
            rv32_exec_pkg::SRA:  result = $signed(op1) >>> shamt;
            rv32_exec_pkg::OR:   result = op1 | op2;
            rv32_exec_pkg::AND:  result = op1 & op2;
            default:             result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rv32_mul_unit.sv ====
// 32x32 multiplier returning the low word or a high word of the product
`timescale 1ns/1ps
`default_nettype none

module rv32_mul_unit (
    input  rv32_types_pkg::rv32_word op1,
    input  rv32_types_pkg::rv32_word op2,
    input  rv32_exec_pkg::mul_op_t   opsel,
    output rv32_types_pkg::rv32_word result
);

    logic               op1_signed, op2_signed;
    logic signed [32:0] op1_ext, op2_ext;
    logic signed [65:0] product;

    // MULHU treats both operands as unsigned, MULHSU only the second
    assign op1_signed = opsel != rv32_exec_pkg::MULHU;
    assign op2_signed = opsel == rv32_exec_pkg::MUL || opsel == rv32_exec_pkg::MULH;

    assign op1_ext = {op1_signed & op1[31], op1};
    assign op2_ext = {op2_signed & op2[31], op2};
    assign product = op1_ext * op2_ext;

    assign result = (opsel == rv32_exec_pkg::MUL) ? product[31:0] : product[63:32];

endmodule

`default_nettype wire

// ==== rv32_types_pkg.sv ====
// Architectural RV32 types shared by the execute stage
// Data word, register index, instruction fields, opcodes and the NOP word
`default_nettype none

package rv32_types_pkg;

    typedef logic [31:0] rv32_word;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // Base R-type layout, other formats reuse the same bit positions
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        funct3_t    funct3;
        reg_idx_t   rd;
        opcode_t    opcode;
    } rv32_instr_t;

    // Major opcodes handled by the execute stage
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    // addi x0, x0, 0
    localparam rv32_word RV_NOP = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== src.f ====
rv32_types_pkg.sv
rv32_exec_pkg.sv
exec_ctrl_if.sv
rv32_exec_ctrl.sv
rv32_immediate_gen.sv
rv32_int_alu.sv
rv32_branch_unit.sv
rv32_mul_unit.sv
rv32_exec_stage.sv
tb_exec_stage.sv

// ==== tb_exec_stage.sv ====
// Random-stimulus testbench for the RV32 execute stage
// Reference model of decode, forwarding, jumps and the exec-to-memory buffer
`timescale 1ns/1ps
`default_nettype none

module tb_exec_stage;

    logic                     clk = 1'b0;
    logic                     resetn, valid, stop, wb_reg_write;
    rv32_types_pkg::rv32_word instr, pc, rs1_data, rs2_data, wb_bypass;
    rv32_types_pkg::reg_idx_t wb_rd;
    logic                     do_jump, out_valid, out_reg_write;
    rv32_types_pkg::rv32_word jump_addr, result, store_data, out_pc, out_instr;
    rv32_types_pkg::reg_idx_t out_rd;

    integer seed = 48;
    int     errors;
    int     checks;

    // Model copy of the buffer, and the value it loads at the next edge
    logic                     m_valid, m_rw, n_valid, n_rw;
    rv32_types_pkg::reg_idx_t m_rd, n_rd;
    rv32_types_pkg::rv32_word m_result, m_sdata, m_pc, m_instr;
    rv32_types_pkg::rv32_word n_result, n_sdata, n_pc, n_instr;

    rv32_exec_stage i_rv32_exec_stage (.*);

    always #50 clk = ~clk;

    task automatic check_word(input string name, input rv32_types_pkg::rv32_word exp, act);
        checks++;
        if (act !== exp) begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input rv32_types_pkg::reg_idx_t exp, act);
        checks++;
        if (act !== exp) begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, act);
        checks++;
        if (act !== exp) begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic rv32_types_pkg::rv32_word rand_word();
        return $random(seed);
    endfunction

    // Legal encodings of each supported kind, plus an unsupported load opcode
    function automatic rv32_types_pkg::rv32_word build_instr();
        rv32_types_pkg::rv32_word r;
        logic [2:0]               f3;
        logic [6:0]               f7;
        logic [4:0]               rs1, rs2, rd;
        r   = rand_word();
        f3  = r[14:12];
        f7  = 7'h00;
        // Few registers so that dependencies show up often
        rs1 = 5'(rnd(8));
        rs2 = 5'(rnd(8));
        rd  = 5'(rnd(8));
        case (rnd(10))
            0: begin
                if ((f3 == 3'b000 || f3 == 3'b101) && r[30])
                    f7 = 7'h20;
                return {f7, rs2, rs1, f3, rd, rv32_types_pkg::OPC_OP};
            end
            1: begin
                if (f3 == 3'b001)
                    f7 = 7'h00;
                else if (f3 == 3'b101)
                    f7 = {1'b0, r[30], 5'b0};
                else
                    f7 = r[31:25];
                return {f7, r[24:20], rs1, f3, rd, rv32_types_pkg::OPC_OP_IMM};
            end
            2: return {r[31:12], rd, rv32_types_pkg::OPC_LUI};
            3: return {r[31:12], rd, rv32_types_pkg::OPC_AUIPC};
            4: return {r[31:12], rd, rv32_types_pkg::OPC_JAL};
            5: return {r[31:20], rs1, 3'b000, rd, rv32_types_pkg::OPC_JALR};
            6: begin
                // funct3 010 and 011 are reserved for branches
                if (f3 == 3'b010 || f3 == 3'b011)
                    f3 = 3'b000;
                return {r[31:25], rs2, rs1, f3, r[11:7], rv32_types_pkg::OPC_BRANCH};
            end
            7: return {r[31:25], rs2, rs1, 3'b010, r[11:7], rv32_types_pkg::OPC_STORE};
            8: return {7'h01, rs2, rs1, {1'b0, r[13:12]}, rd, rv32_types_pkg::OPC_OP};
            default: return {r[31:7], 7'b0000011};
        endcase
    endfunction

    // Newest producer wins, x0 never forwards from write-back
    function automatic rv32_types_pkg::rv32_word forward(input rv32_types_pkg::reg_idx_t src,
                                                         input rv32_types_pkg::rv32_word data);
        if (m_rw && m_rd == src)
            return m_result;
        if (wb_reg_write && wb_rd == src && src != 5'd0)
            return wb_bypass;
        return data;
    endfunction

    function automatic rv32_types_pkg::rv32_word alu_word(input rv32_types_pkg::rv32_word a, b,
                                                          input logic [2:0] f3,
                                                          input logic alt);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic rv32_types_pkg::rv32_word mul_word(input rv32_types_pkg::rv32_word a, b,
                                                          input logic [1:0] kind);
        logic [63:0] sa, sb, ua, ub, prod;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'd0, a};
        ub = {32'd0, b};
        case (kind)
            2'd0, 2'd1: prod = sa * sb;
            2'd2:       prod = sa * ub;
            default:    prod = ua * ub;
        endcase
        return (kind == 2'd0) ? prod[31:0] : prod[63:32];
    endfunction

    function automatic logic branch_taken(input rv32_types_pkg::rv32_word a, b,
                                          input logic [2:0] f3);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check_buffer();
        check_bit("out_valid", m_valid, out_valid);
        check_bit("out_reg_write", m_rw, out_reg_write);
        check_reg("out_rd", m_rd, out_rd);
        check_word("out_pc", m_pc, out_pc);
        check_word("out_instr", m_instr, out_instr);
        if (m_valid) begin
            check_word("result", m_result, result);
            check_word("store_data", m_sdata, store_data);
        end
    endtask

    // Model of the current slot, checks the jump outputs
    task automatic predict();
        rv32_types_pkg::rv32_instr_t ins;
        rv32_types_pkg::rv32_word    a, b, rhs, res, target;
        rv32_types_pkg::rv32_word    imm_i, imm_s, imm_b, imm_u, imm_j;
        logic                        known, rw, taken, alt;
        ins    = instr;
        a      = forward(ins.rs1, rs1_data);
        b      = forward(ins.rs2, rs2_data);
        imm_i  = {{20{instr[31]}}, instr[31:20]};
        imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_u  = {instr[31:12], 12'h000};
        imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        known  = 1'b1;
        rw     = 1'b1;
        taken  = 1'b0;
        res    = '0;
        target = '0;
        case (ins.opcode)
            rv32_types_pkg::OPC_OP, rv32_types_pkg::OPC_OP_IMM: begin
                rhs = (ins.opcode == rv32_types_pkg::OPC_OP) ? b : imm_i;
                alt = ins.funct7[5]
                      && (ins.opcode == rv32_types_pkg::OPC_OP || ins.funct3 == 3'b101);
                if (ins.opcode == rv32_types_pkg::OPC_OP && ins.funct7[0])
                    res = mul_word(a, b, ins.funct3[1:0]);
                else
                    res = alu_word(a, rhs, ins.funct3, alt);
            end
            rv32_types_pkg::OPC_LUI:   res = imm_u;
            rv32_types_pkg::OPC_AUIPC: res = pc + imm_u;
            rv32_types_pkg::OPC_JAL: begin
                res    = pc + 32'd4;
                target = pc + imm_j;
                taken  = 1'b1;
            end
            rv32_types_pkg::OPC_JALR: begin
                res    = pc + 32'd4;
                target = a + imm_i;
                taken  = 1'b1;
            end
            rv32_types_pkg::OPC_BRANCH: begin
                rw     = 1'b0;
                target = pc + imm_b;
                taken  = branch_taken(a, b, ins.funct3);
            end
            rv32_types_pkg::OPC_STORE: begin
                rw  = 1'b0;
                res = a + imm_s;
            end
            default: begin
                known = 1'b0;
                rw    = 1'b0;
            end
        endcase
        check_bit("do_jump", valid && known && taken, do_jump);
        if (valid && known && taken)
            check_word("jump_addr", target & 32'hffff_fffe, jump_addr);
        n_valid  = valid && known;
        n_rw     = valid && known && rw && ins.rd != 5'd0;
        n_rd     = ins.rd;
        n_pc     = pc;
        n_instr  = instr;
        n_result = res;
        n_sdata  = b;
    endtask

    // One clock: update the model buffer, drive the next slot, check at the falling edge
    task automatic run_cycle(input logic active);
        rv32_types_pkg::rv32_word r1;
        @(posedge clk);
        if (!stop) begin
            m_valid  = n_valid;
            m_rw     = n_rw;
            m_rd     = n_rd;
            m_pc     = n_pc;
            m_instr  = n_instr;
            m_result = n_result;
            m_sdata  = n_sdata;
            // A stalled slot stays put until it is taken
            if (active) begin
                r1 = rand_word();
                valid    <= rnd(10) < 8;
                instr    <= build_instr();
                pc       <= rand_word() & 32'hffff_fffc;
                rs1_data <= r1;
                rs2_data <= (rnd(4) == 0) ? r1 : rand_word();
            end else begin
                valid <= 1'b0;
            end
        end
        stop         <= active && (rnd(100) < 15);
        wb_reg_write <= rnd(2) == 0;
        wb_rd        <= 5'(rnd(8));
        wb_bypass    <= rand_word();
        @(negedge clk);
        check_buffer();
        predict();
    endtask

    initial begin
        int n;
        errors       = 0;
        checks       = 0;
        resetn       = 1'b0;
        valid        = 1'b0;
        stop         = 1'b0;
        instr        = rv32_types_pkg::RV_NOP;
        pc           = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        wb_bypass    = '0;
        wb_rd        = '0;
        wb_reg_write = 1'b0;
        m_valid      = 1'b0;
        m_rw         = 1'b0;
        m_rd         = '0;
        m_pc         = '0;
        m_instr      = rv32_types_pkg::RV_NOP;
        m_result     = '0;
        m_sdata      = '0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_buffer();
        predict();
        repeat (3000) run_cycle(1'b1);
        // Drain with no new slots, the buffer must empty
        n = 0;
        do begin
            run_cycle(1'b0);
            n++;
        end while (out_valid && n < 20);
        if (out_valid) begin
            $display("Timeout: buffer still holds a valid slot after the input stream ended");
            errors++;
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire
